// File: include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width
`define CPU_XLEN      32

// integer register file
`define CPU_REG_COUNT 32
`define CPU_REG_IDX_W 5

// program counter
`define CPU_RESET_PC  0
`define CPU_PC_STEP   4   // one word per instruction

`endif

// File: src/bus_pkg.sv
`include "cpu_defines.svh"

package bus_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_XLEN-1:0] addr_t;   // byte address

    // external bus controller
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQUEST = 2'd1,
        WAIT    = 2'd2,   // bus full, hold off
        ACCESS  = 2'd3
    } bus_state_e;

endpackage

// File: src/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef logic [2:0] funct3_t;

    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        XOR    = 3'd2,
        OR     = 3'd3,
        AND    = 3'd4,
        SLL    = 3'd5,
        SRL    = 3'd6,
        PASS_B = 3'd7   // lui, operand b straight through
    } alu_op_e;

endpackage

// File: src/cpu_ifs.sv
`timescale 1ns/1ps

// one memory requester towards the bus controller
interface mem_req_if;
    logic           req;     // level, held until done
    logic           we;
    bus_pkg::addr_t addr;
    bus_pkg::word_t wdata;
    logic           done;    // single cycle
    bus_pkg::word_t rdata;   // valid with done

    modport requester (
        output req, we, addr, wdata,
        input  done, rdata
    );

    modport server (
        input  req, we, addr, wdata,
        output done, rdata
    );
endinterface

// instruction hand-off between fetch and execute
interface issue_if;
    logic           instr_valid;
    bus_pkg::word_t instr;
    bus_pkg::addr_t pc;
    logic           retire;
    logic           redirect;   // qualified by retire
    bus_pkg::addr_t target;

    modport fetch (
        output instr_valid, instr, pc,
        input  retire, redirect, target
    );

    modport exec (
        input  instr_valid, instr, pc,
        output retire, redirect, target
    );
endinterface

// File: src/register_file.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              we_i,
    input  isa_pkg::reg_idx_t rd_i,
    input  bus_pkg::word_t    wdata_i,
    input  isa_pkg::reg_idx_t rs1_i,
    input  isa_pkg::reg_idx_t rs2_i,
    output bus_pkg::word_t    rdata1_o,
    output bus_pkg::word_t    rdata2_o
);

    bus_pkg::word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin   // x0 is hardwired
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[rs1_i];
    assign rdata2_o = regs[rs2_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1_i == '0) |-> (rdata1_o == '0));

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit (
    input  logic         clk,
    input  logic         rst,
    mem_req_if.requester mem,
    issue_if.fetch       iss
);

    typedef enum logic {
        FETCH,
        HOLD     // instruction out, waiting for retire
    } fetch_state_e;

    fetch_state_e   state;
    bus_pkg::addr_t pc;
    bus_pkg::word_t instr_q;
    logic           req_q;
    logic           valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= FETCH;
            pc      <= bus_pkg::addr_t'(`CPU_RESET_PC);
            req_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                FETCH: begin
                    if (mem.done) begin
                        state   <= HOLD;
                        req_q   <= 1'b0;
                        valid_q <= 1'b1;
                    end else begin
                        req_q <= 1'b1;   // first request after reset
                    end
                end
                HOLD: begin
                    if (iss.retire) begin
                        state <= FETCH;
                        req_q <= 1'b1;   // next fetch right away
                        pc    <= iss.redirect ? iss.target
                                              : pc + bus_pkg::addr_t'(`CPU_PC_STEP);
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // instruction word stays put until the next fetch completes
    always_ff @(posedge clk) begin
        if (mem.done) begin
            instr_q <= mem.rdata;
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;   // fetch only reads
    assign mem.addr  = pc;
    assign mem.wdata = '0;

    assign iss.instr_valid = valid_q;
    assign iss.instr       = instr_q;
    assign iss.pc          = pc;

    // execute retires only the instruction held here, never with a new one
    a_retire_in_hold: assert property (@(posedge clk) disable iff (rst)
        iss.retire |-> (state == HOLD && !iss.instr_valid));

endmodule

// File: src/bus_controller.sv
`timescale 1ns/1ps

module bus_controller (
    input  logic           clk,
    input  logic           rst,
    mem_req_if.server      fetch_port,
    mem_req_if.server      data_port,
    input  bus_pkg::word_t bus_rdata_i,
    input  logic           bus_full_i,
    output logic           bus_rd_o,
    output logic           bus_wr_o,
    output bus_pkg::addr_t bus_addr_o,
    output bus_pkg::word_t bus_wdata_o
);

    bus_pkg::bus_state_e state;
    bus_pkg::bus_state_e state_nxt;
    logic                grant_data;   // data port owns the current transaction
    logic                strobe;
    logic                sel_we;
    bus_pkg::addr_t      sel_addr;
    bus_pkg::word_t      sel_wdata;

    always_comb begin
        state_nxt = state;
        case (state)
            bus_pkg::IDLE: begin
                if (data_port.req || fetch_port.req) state_nxt = bus_pkg::REQUEST;
            end
            bus_pkg::REQUEST: state_nxt = bus_full_i ? bus_pkg::WAIT : bus_pkg::ACCESS;
            bus_pkg::WAIT: begin
                if (!bus_full_i) state_nxt = bus_pkg::ACCESS;
            end
            bus_pkg::ACCESS: begin
                // a full bus in ACCESS just delays the strobe by a cycle
                if (!bus_full_i) state_nxt = bus_pkg::IDLE;
            end
            default: state_nxt = bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= bus_pkg::IDLE;
            grant_data <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == bus_pkg::IDLE) begin
                if (data_port.req) begin
                    grant_data <= 1'b1;   // data wins over fetch
                end else if (fetch_port.req) begin
                    grant_data <= 1'b0;
                end
            end
        end
    end

    assign sel_we    = grant_data ? data_port.we    : fetch_port.we;
    assign sel_addr  = grant_data ? data_port.addr  : fetch_port.addr;
    assign sel_wdata = grant_data ? data_port.wdata : fetch_port.wdata;

    assign strobe = (state == bus_pkg::ACCESS) && !bus_full_i;

    assign bus_rd_o    = strobe && !sel_we;
    assign bus_wr_o    = strobe && sel_we;
    assign bus_addr_o  = (state == bus_pkg::ACCESS) ? sel_addr : '0;
    assign bus_wdata_o = (state == bus_pkg::ACCESS && sel_we) ? sel_wdata : '0;

    // done and read data go back to the granted port only
    assign fetch_port.done  = strobe && !grant_data;
    assign data_port.done   = strobe && grant_data;
    assign fetch_port.rdata = grant_data ? '0 : bus_rdata_i;
    assign data_port.rdata  = grant_data ? bus_rdata_i : '0;

    // only the data port ever writes
    a_wr_from_data: assert property (@(posedge clk) disable iff (rst)
        bus_wr_o |-> grant_data);

    // granted requester still holds req when its access happens
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (bus_rd_o || bus_wr_o) |-> (grant_data ? data_port.req : fetch_port.req));

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_unit (
    input  logic         clk,
    input  logic         rst,
    issue_if.exec        iss,
    mem_req_if.requester mem
);

    typedef enum logic {
        EXEC,
        MEM_WAIT   // load or store on the bus
    } exec_state_e;

    exec_state_e       state;
    isa_pkg::opcode_e  opcode;
    isa_pkg::funct3_t  funct3;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::reg_idx_t rd;
    isa_pkg::alu_op_e  alu_op;
    bus_pkg::word_t    instr;
    bus_pkg::word_t    imm;
    bus_pkg::word_t    rs1_val;
    bus_pkg::word_t    rs2_val;
    bus_pkg::word_t    op_b;
    bus_pkg::word_t    alu_res;
    bus_pkg::word_t    wb_data;
    bus_pkg::word_t    load_data;
    logic              is_mem;
    logic              writes_rd;
    logic              taken;
    logic              retire_q;

    // fetch holds the instruction until retire
    assign instr  = iss.instr;
    assign opcode = isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        case (opcode)
            isa_pkg::OP_IMM,
            isa_pkg::LOAD:   imm = {{20{instr[31]}}, instr[31:20]};
            isa_pkg::STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            isa_pkg::BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7],
                                    instr[30:25], instr[11:8], 1'b0};
            isa_pkg::JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                    instr[20], instr[30:21], 1'b0};
            isa_pkg::LUI:    imm = {instr[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    always_comb begin
        alu_op = isa_pkg::ADD;
        if (opcode == isa_pkg::OP || opcode == isa_pkg::OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // sub exists only in register form
                    if (opcode == isa_pkg::OP && instr[30]) alu_op = isa_pkg::SUB;
                    else alu_op = isa_pkg::ADD;
                end
                3'b100:  alu_op = isa_pkg::XOR;
                3'b110:  alu_op = isa_pkg::OR;
                3'b111:  alu_op = isa_pkg::AND;
                3'b001:  alu_op = isa_pkg::SLL;
                3'b101:  alu_op = isa_pkg::SRL;
                default: alu_op = isa_pkg::ADD;
            endcase
        end else if (opcode == isa_pkg::LUI) begin
            alu_op = isa_pkg::PASS_B;
        end
    end

    assign op_b = (opcode == isa_pkg::OP) ? rs2_val : imm;

    always_comb begin
        case (alu_op)
            isa_pkg::ADD:    alu_res = rs1_val + op_b;
            isa_pkg::SUB:    alu_res = rs1_val - op_b;
            isa_pkg::XOR:    alu_res = rs1_val ^ op_b;
            isa_pkg::OR:     alu_res = rs1_val | op_b;
            isa_pkg::AND:    alu_res = rs1_val & op_b;
            isa_pkg::SLL:    alu_res = rs1_val << op_b[4:0];
            isa_pkg::SRL:    alu_res = rs1_val >> op_b[4:0];
            default:         alu_res = op_b;   // pass b
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:         taken = (rs1_val == rs2_val);
            3'b001:         taken = (rs1_val != rs2_val);
            3'b100, 3'b110: taken = (rs1_val < rs2_val);    // unsigned compare
            3'b101, 3'b111: taken = (rs1_val >= rs2_val);
            default:        taken = 1'b0;
        endcase
    end

    assign is_mem    = (opcode == isa_pkg::LOAD) || (opcode == isa_pkg::STORE);
    assign writes_rd = (opcode == isa_pkg::OP) || (opcode == isa_pkg::OP_IMM) ||
                       (opcode == isa_pkg::LUI) || (opcode == isa_pkg::JAL) ||
                       (opcode == isa_pkg::LOAD);

    always_comb begin
        case (opcode)
            isa_pkg::LOAD: wb_data = load_data;
            isa_pkg::JAL:  wb_data = iss.pc + bus_pkg::addr_t'(`CPU_PC_STEP);   // link
            default:       wb_data = alu_res;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= EXEC;
            retire_q <= 1'b0;
        end else begin
            retire_q <= 1'b0;
            case (state)
                EXEC: begin
                    if (iss.instr_valid) begin
                        if (is_mem) state <= MEM_WAIT;
                        else retire_q <= 1'b1;   // unknown opcodes land here too
                    end
                end
                MEM_WAIT: begin
                    if (mem.done) begin
                        state    <= EXEC;
                        retire_q <= 1'b1;
                    end
                end
                default: state <= EXEC;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem.done) begin
            load_data <= mem.rdata;
        end
    end

    register_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .we_i     (retire_q && writes_rd),   // write back in the retire cycle
        .rd_i     (rd),
        .wdata_i  (wb_data),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val)
    );

    assign mem.req   = (state == MEM_WAIT);
    assign mem.we    = (opcode == isa_pkg::STORE);
    assign mem.addr  = rs1_val + imm;
    assign mem.wdata = rs2_val;

    assign iss.retire   = retire_q;
    assign iss.redirect = (opcode == isa_pkg::JAL) || (opcode == isa_pkg::BRANCH && taken);
    assign iss.target   = iss.pc + imm;

endmodule

// File: src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  bus_pkg::word_t bus_rdata_i,
    input  logic           bus_full_i,
    output logic           bus_rd_o,
    output logic           bus_wr_o,
    output bus_pkg::addr_t bus_addr_o,
    output bus_pkg::word_t bus_wdata_o
);

    mem_req_if fetch_port ();
    mem_req_if data_port ();
    issue_if   issue ();

    fetch_unit u_fetch (
        .clk (clk),
        .rst (rst),
        .mem (fetch_port.requester),
        .iss (issue.fetch)
    );

    execute_unit u_exec (
        .clk (clk),
        .rst (rst),
        .iss (issue.exec),
        .mem (data_port.requester)
    );

    bus_controller u_bus (
        .clk         (clk),
        .rst         (rst),
        .fetch_port  (fetch_port.server),
        .data_port   (data_port.server),
        .bus_rdata_i (bus_rdata_i),
        .bus_full_i  (bus_full_i),
        .bus_rd_o    (bus_rd_o),
        .bus_wr_o    (bus_wr_o),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o)
    );

endmodule

// File: sim/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;

    localparam bus_pkg::word_t HALT = 32'h0000_006f;   // jal x0, 0
    localparam int MEM_WORDS = 256;

    logic           clk = 1'b0;
    logic           rst = 1'b1;
    logic           bus_full = 1'b0;
    bus_pkg::word_t bus_rdata;
    logic           bus_rd;
    logic           bus_wr;
    bus_pkg::addr_t bus_addr;
    bus_pkg::word_t bus_wdata;

    bus_pkg::word_t dmem [MEM_WORDS];   // memory seen by the DUT
    bus_pkg::word_t img  [MEM_WORDS];   // program image to load
    bus_pkg::word_t mmem [MEM_WORDS];   // model's own copy
    bus_pkg::addr_t exp_addr [$];
    bus_pkg::word_t exp_data [$];
    bus_pkg::addr_t want_addr;
    bus_pkg::word_t want_data;

    integer seed = 32'hd0e8;
    integer rnd;
    logic   full_on = 1'b0;
    logic   mem_load = 1'b0;
    logic   timed_out = 1'b0;
    int     prog_len;
    int     tests = 0;
    int     bus_errors = 0;
    int     bus_checks = 0;
    int     seq_errors = 0;
    int     seq_checks = 0;

    cpu_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .bus_rdata_i (bus_rdata),
        .bus_full_i  (bus_full),
        .bus_rd_o    (bus_rd),
        .bus_wr_o    (bus_wr),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata)
    );

    always #4 clk = ~clk;

    // back-pressure source, one draw per cycle
    always @(negedge clk) begin
        rnd = $random(seed);
        bus_full <= full_on & rnd[0];
    end

    // memory answers in the strobe cycle
    assign bus_rdata = dmem[bus_addr[9:2]];

    always @(posedge clk) begin
        if (mem_load) begin
            for (int i = 0; i < MEM_WORDS; i++) dmem[i] <= img[i];
        end else if (bus_wr) begin
            dmem[bus_addr[9:2]] <= bus_wdata;
        end
    end

    // compare stores against the model, watch the strobes
    always @(posedge clk) begin
        if (rst) begin
            bus_checks++;
            assert (!bus_rd && !bus_wr) else begin
                $display("** Error at %0t: bus strobe active during reset", $time);
                bus_errors++;
            end
        end else begin
            bus_checks++;
            assert (!(bus_full && (bus_rd || bus_wr))) else begin
                $display("** Error at %0t: strobe while bus_full_i was high", $time);
                bus_errors++;
            end
            if (bus_wr) begin
                bus_checks++;
                assert (exp_addr.size() != 0) else begin
                    $display("** Error at %0t: store to %h that the model never makes",
                             $time, bus_addr);
                    bus_errors++;
                end
            end
            if (bus_wr && exp_addr.size() != 0) begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                bus_checks += 2;
                assert (bus_addr == want_addr) else begin
                    $display("** Error at %0t: bus_addr_o = %h, expected %h",
                             $time, bus_addr, want_addr);
                    bus_errors++;
                end
                assert (bus_wdata == want_data) else begin
                    $display("** Error at %0t: bus_wdata_o = %h, expected %h",
                             $time, bus_wdata, want_data);
                    bus_errors++;
                end
            end
        end
    end

    function automatic bus_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic bus_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic bus_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic bus_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic bus_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic bus_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    // spec semantics for the register and immediate ALU forms
    function automatic bus_pkg::word_t alu_ref(input logic [2:0] f3, input logic sub,
            input bus_pkg::word_t a, input bus_pkg::word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            3'b001:  return a << b[4:0];
            3'b101:  return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input bus_pkg::word_t a,
            input bus_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return a < b;    // both compares unsigned in this core
            3'b101:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // instruction-set model, fills the expected store list
    function automatic int run_model();
        bus_pkg::word_t regs [32];
        bus_pkg::word_t pc;
        bus_pkg::word_t nxt;
        bus_pkg::word_t ins;
        bus_pkg::word_t a;
        bus_pkg::word_t b;
        bus_pkg::word_t ea;
        bus_pkg::word_t res;
        logic           wr;
        logic           halted;
        int             n;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) mmem[i] = img[i];
        exp_addr.delete();
        exp_data.delete();
        pc = bus_pkg::word_t'(`CPU_RESET_PC);
        n = 0;
        halted = 1'b0;
        while (!halted && n < 2000) begin
            ins = mmem[pc[9:2]];
            n++;
            halted = (ins == HALT);
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            nxt = pc + 32'd4;
            wr = 1'b0;
            res = '0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    res = alu_ref(ins[14:12], ins[30], a, b);
                end
                7'h13: begin
                    wr = 1'b1;
                    res = alu_ref(ins[14:12], 1'b0, a, 32'($signed(ins[31:20])));
                end
                7'h37: begin
                    wr = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                7'h03: begin
                    ea = a + 32'($signed(ins[31:20]));
                    wr = 1'b1;
                    res = mmem[ea[9:2]];
                end
                7'h23: begin
                    ea = a + 32'($signed({ins[31:25], ins[11:7]}));
                    mmem[ea[9:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                7'h63: begin
                    if (branch_ref(ins[14:12], a, b))
                        nxt = pc + 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
                end
                7'h6f: begin
                    wr = 1'b1;
                    res = pc + 32'd4;   // link
                    nxt = pc + 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
            pc = nxt;
        end
        return n;
    endfunction

    task automatic emit(input bus_pkg::word_t w);
        img[prog_len] = w;
        prog_len++;
    endtask

    // fill pattern from the full word index, then program from 0
    task automatic clear_image();
        for (int i = 0; i < MEM_WORDS; i++) img[i] = 32'hc3a5_0000 ^ (32'(i) * 32'h0001_0407);
        prog_len = 0;
    endtask

    task automatic alu_program();
        clear_image();
        emit(u_type(20'h12345, 5'd1));
        emit(i_type(12'h678, 5'd1, 3'b000, 5'd1, 7'h13));   // x1 = 0x12345678
        emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, 7'h13));   // x2 = -3
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd8, 7'h13));
        emit(r_type(7'h00, 5'd8, 5'd1, 3'b001, 5'd9));
        emit(r_type(7'h00, 5'd8, 5'd2, 3'b101, 5'd10));     // logical shift of a negative
        emit(i_type(12'hfff, 5'd1, 3'b100, 5'd11, 7'h13));
        emit(i_type(12'h0f0, 5'd2, 3'b110, 5'd12, 7'h13));
        emit(i_type(12'h7ff, 5'd1, 3'b111, 5'd13, 7'h13));
        emit(i_type(12'd4, 5'd1, 3'b001, 5'd14, 7'h13));
        emit(i_type(12'd28, 5'd2, 3'b101, 5'd15, 7'h13));
        for (int r = 1; r < 16; r++) emit(s_type(12'h200 + 12'(4 * r), 5'(r), 5'd0));
        emit(HALT);
    endtask

    task automatic load_store_program();
        clear_image();
        emit(i_type(12'h300, 5'd0, 3'b000, 5'd1, 7'h13));   // base
        emit(i_type(12'd0, 5'd1, 3'b010, 5'd2, 7'h03));
        emit(i_type(12'd4, 5'd1, 3'b010, 5'd3, 7'h03));
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
        emit(s_type(12'd8, 5'd4, 5'd1));
        emit(i_type(12'd8, 5'd1, 3'b010, 5'd5, 7'h03));     // read back own store
        emit(i_type(12'h055, 5'd5, 3'b100, 5'd5, 7'h13));
        emit(s_type(12'd12, 5'd5, 5'd1));
        emit(i_type(12'hffc, 5'd1, 3'b010, 5'd6, 7'h03));   // negative offset
        emit(r_type(7'h20, 5'd2, 5'd6, 3'b000, 5'd7));
        emit(s_type(12'd0, 5'd7, 5'd1));
        emit(i_type(12'd0, 5'd1, 3'b010, 5'd8, 7'h03));
        emit(s_type(12'd16, 5'd8, 5'd1));
        emit(HALT);
    endtask

    // a store after a taken branch marks the wrong path
    task automatic branch_program();
        clear_image();
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'h13));
        emit(i_type(12'hfff, 5'd0, 3'b000, 5'd3, 7'h13));   // x3 all ones
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));            // beq taken
        emit(s_type(12'h200, 5'd3, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'b000));            // beq not taken
        emit(s_type(12'h204, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));            // bne not taken
        emit(s_type(12'h208, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'b001));            // bne taken
        emit(s_type(12'h20c, 5'd3, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'b100));            // blt taken
        emit(s_type(12'h210, 5'd3, 5'd0));
        emit(b_type(13'd8, 5'd1, 5'd3, 3'b100));            // blt not taken
        emit(s_type(12'h214, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd1, 5'd3, 3'b101));            // bge taken
        emit(s_type(12'h218, 5'd3, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'b101));            // bge not taken
        emit(s_type(12'h21c, 5'd1, 5'd0));
        emit(j_type(21'd8, 5'd5));
        emit(s_type(12'h220, 5'd3, 5'd0));
        emit(s_type(12'h224, 5'd5, 5'd0));                  // link value
        emit(HALT);
    endtask

    // reset for 10 cycles while the image goes into memory
    task automatic restart(input logic use_full);
        @(negedge clk);
        rst = 1'b1;
        full_on = 1'b0;
        mem_load = 1'b1;
        @(negedge clk);
        mem_load = 1'b0;
        full_on = use_full;
        repeat (9) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic print_result(input string name, input int err_before);
        int n;
        n = bus_errors + seq_errors - err_before;
        tests++;
        if (n == 0) $display("test %0d (%s): ok", tests, name);
        else $display("test %0d (%s): %0d errors", tests, name, n);
    endtask

    task automatic check_reset_fetch();
        int   cycles;
        int   err_before;
        logic seen;
        err_before = bus_errors + seq_errors;
        alu_program();
        exp_addr.delete();
        exp_data.delete();
        restart(1'b0);
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 60) begin
            @(posedge clk);
            cycles++;
            seen = bus_rd;
        end
        if (!seen) begin
            $display("timeout: no instruction fetch within 60 cycles after reset");
            seq_errors++;
            timed_out = 1'b1;
        end else begin
            seq_checks++;
            assert (bus_addr == bus_pkg::addr_t'(`CPU_RESET_PC)) else begin
                $display("** Error at %0t: bus_addr_o = %h, expected %h",
                         $time, bus_addr, bus_pkg::addr_t'(`CPU_RESET_PC));
                seq_errors++;
            end
        end
        print_result("reset and first fetch", err_before);
    endtask

    task automatic run_program(input string name, input logic use_full);
        int n_exec;
        int limit;
        int cycles;
        int err_before;
        err_before = bus_errors + seq_errors;
        n_exec = run_model();
        limit = 60 * n_exec;
        restart(use_full);
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            $display("timeout: %s still misses %0d stores after %0d cycles",
                     name, exp_addr.size(), limit);
            seq_errors++;
            timed_out = 1'b1;
        end else begin
            repeat (20) @(negedge clk);   // room for stray stores
        end
        print_result(name, err_before);
    endtask

    initial begin
        check_reset_fetch();
        if (!timed_out) begin
            alu_program();
            run_program("alu", 1'b0);
        end
        if (!timed_out) begin
            load_store_program();
            run_program("load and store", 1'b0);
        end
        if (!timed_out) begin
            branch_program();
            run_program("branches and jal", 1'b0);
        end
        if (!timed_out) begin
            load_store_program();
            run_program("back-pressure", 1'b1);
        end
        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests, bus_checks + seq_checks, bus_errors + seq_errors);
        if (bus_errors + seq_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
src/bus_pkg.sv
src/isa_pkg.sv
src/cpu_ifs.sv
src/register_file.sv
src/fetch_unit.sv
src/bus_controller.sv
src/execute_unit.sv
src/cpu_top.sv
sim/cpu_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = cpu_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), pass if the log shows the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
